//--- rtl/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] instrT;

    // opcode field
    localparam int OP_MSB = 31;
    localparam int OP_LSB = 26;

    // REGIMM branch selector lives in the rt field
    localparam int REGIMM_SEL_MSB = 19;
    localparam int REGIMM_SEL_LSB = 17;

    localparam logic [5:0] OP_REGIMM = 6'b000001;

    // beq, bne, blez, bgtz share this opcode prefix
    localparam logic [3:0] OP_BRANCH_HI = 4'b0001;

    function automatic logic isBranch(instrT instr);
        logic [2:0] regimmSel;
        logic regimmBranch;
        logic groupBranch;
        regimmSel = instr[REGIMM_SEL_MSB:REGIMM_SEL_LSB];
        // 000 is bltz/bgez and links, 001 the likely forms
        regimmBranch = (instr[OP_MSB:OP_LSB] == OP_REGIMM) &&
                       (regimmSel == 3'b000 || regimmSel == 3'b001);
        groupBranch = (instr[OP_MSB:OP_MSB-3] == OP_BRANCH_HI);
        return regimmBranch || groupBranch;
    endfunction

endpackage

//--- rtl/bpPkg.sv
package bpPkg;

    // bit 1 is the predicted direction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b11,
        STRONG_T  = 2'b10
    } counterT;

    function automatic counterT stepCounter(counterT state, logic taken);
        counterT nextState;
        case (state)
            STRONG_NT: nextState = taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   nextState = taken ? WEAK_T : STRONG_NT;
            WEAK_T:    nextState = taken ? STRONG_T : WEAK_NT;
            default:   nextState = taken ? STRONG_T : WEAK_T;
        endcase
        return nextState;
    endfunction

endpackage

//--- rtl/pcGen.sv
`timescale 1ns/1ps

module pcGen #(
    parameter logic [31:0] resetPc = 32'hBFC00000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    output logic [31:0] pcF2
);

    // redirect wins over stall, otherwise step one word
    always_ff @(posedge clk) begin
        if (rst) begin
            pcF2 <= resetPc;
        end else if (redirect) begin
            pcF2 <= redirectPc;
        end else if (!stall) begin
            pcF2 <= pcF2 + 32'd4;
        end
    end

endmodule

//--- rtl/fetchDecodeReg.sv
`timescale 1ns/1ps

module fetchDecodeReg (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           flush,
    input  logic [31:0]    pcF2,
    input  mipsPkg::instrT instrF2,
    output logic           validD,
    output logic [31:0]    pcD,
    output mipsPkg::instrT instrD
);

    // valid bit keeps flushed slots from looking like branches
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validD <= 1'b0;
        end else if (!stall) begin
            validD <= 1'b1;
        end
    end

    // cleared too, so an empty slot decodes as a plain zero word
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pcD    <= '0;
            instrD <= '0;
        end else if (!stall) begin
            pcD    <= pcF2;
            instrD <= instrF2;
        end
    end

endmodule

//--- rtl/localHistoryTable.sv
`timescale 1ns/1ps

module localHistoryTable #(
    parameter int indexBits   = 10,
    parameter int historyBits = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [indexBits-1:0]   lookupIndex,
    input  logic [indexBits-1:0]   updateIndex,
    input  logic                   updateEn,
    input  logic                   updateTaken,
    output logic [historyBits-1:0] lookupHistory,
    output logic [historyBits-1:0] updateHistory
);

    localparam int entries = 1 << indexBits;

    logic [historyBits-1:0] histories [entries];

    // both reads are combinational, old contents during a write
    assign lookupHistory = histories[lookupIndex];
    assign updateHistory = histories[updateIndex];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                histories[i] <= '0;
            end
        end else if (updateEn) begin
            // newest outcome enters at bit 0
            histories[updateIndex] <= {updateHistory[historyBits-2:0], updateTaken};
        end
    end

endmodule

//--- rtl/patternCounterTable.sv
`timescale 1ns/1ps

module patternCounterTable #(
    parameter int historyBits = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [historyBits-1:0] lookupIndex,
    input  logic [historyBits-1:0] updateIndex,
    input  logic                   updateEn,
    input  logic                   updateTaken,
    output logic                   lookupTake
);

    import bpPkg::*;

    localparam int entries = 1 << historyBits;

    counterT counters [entries];
    counterT lookupEntry;
    counterT updateEntry;

    assign lookupEntry = counters[lookupIndex];
    assign updateEntry = counters[updateIndex];

    // direction is the counter msb
    assign lookupTake = lookupEntry[1];

    // only resolved branches train, idle cycles leave counters alone
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= STRONG_NT;
            end
        end else if (updateEn) begin
            counters[updateIndex] <= stepCounter(updateEntry, updateTaken);
        end
    end

endmodule

//--- rtl/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor #(
    parameter int indexBits   = 10,
    parameter int historyBits = 6
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           flush,
    input  logic [31:0]    pcF2,
    input  logic           validD,
    input  mipsPkg::instrT instrD,
    input  logic           branchE,
    input  logic [31:0]    pcE,
    input  logic           actualTakeE,
    output logic           branchD,
    output logic           predTakeD
);

    import mipsPkg::*;

    logic [historyBits-1:0] lookupHistory;
    logic [historyBits-1:0] updateHistory;
    logic                   predTakeF2;
    logic                   predTakeReg;

    // word index, byte offset dropped
    localHistoryTable #(
        .indexBits  (indexBits),
        .historyBits(historyBits)
    ) historyTable (
        .clk          (clk),
        .rst          (rst),
        .lookupIndex  (pcF2[indexBits+1:2]),
        .updateIndex  (pcE[indexBits+1:2]),
        .updateEn     (branchE),
        .updateTaken  (actualTakeE),
        .lookupHistory(lookupHistory),
        .updateHistory(updateHistory)
    );

    // training uses the history from before its own shift
    patternCounterTable #(
        .historyBits(historyBits)
    ) counterTable (
        .clk        (clk),
        .rst        (rst),
        .lookupIndex(lookupHistory),
        .updateIndex(updateHistory),
        .updateEn   (branchE),
        .updateTaken(actualTakeE),
        .lookupTake (predTakeF2)
    );

    // same rule as the decode register so it stays with instrD
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            predTakeReg <= 1'b0;
        end else if (!stall) begin
            predTakeReg <= predTakeF2;
        end
    end

    assign branchD   = validD && isBranch(instrD);
    assign predTakeD = branchD && predTakeReg;

endmodule

//--- rtl/bpFrontEnd.sv
`timescale 1ns/1ps

module bpFrontEnd #(
    parameter logic [31:0] resetPc     = 32'hBFC00000,
    parameter int          indexBits   = 10,
    parameter int          historyBits = 6
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           flush,
    input  logic           redirect,
    input  logic [31:0]    redirectPc,
    input  mipsPkg::instrT instrF2,
    input  logic           branchE,
    input  logic [31:0]    pcE,
    input  logic           actualTakeE,
    output logic [31:0]    pcF2,
    output logic           validD,
    output logic [31:0]    pcD,
    output mipsPkg::instrT instrD,
    output logic           branchD,
    output logic           predTakeD
);

    pcGen #(
        .resetPc(resetPc)
    ) pcGenInst (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .pcF2      (pcF2)
    );

    fetchDecodeReg fetchDecodeRegInst (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .pcF2   (pcF2),
        .instrF2(instrF2),
        .validD (validD),
        .pcD    (pcD),
        .instrD (instrD)
    );

    // looks up with pcF2, trains from execute
    branchPredictor #(
        .indexBits  (indexBits),
        .historyBits(historyBits)
    ) branchPredictorInst (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .pcF2       (pcF2),
        .validD     (validD),
        .instrD     (instrD),
        .branchE    (branchE),
        .pcE        (pcE),
        .actualTakeE(actualTakeE),
        .branchD    (branchD),
        .predTakeD  (predTakeD)
    );

endmodule

//--- verif/clkGen.sv
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verif/bpFrontEnd_checker.sv
`timescale 1ns/1ps

module bpFrontEnd_checker (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        flush,
    input logic        validD,
    input logic [31:0] pcD,
    input logic        branchD,
    input logic        predTakeD
);

    int predFails = 0;
    int branchFails = 0;
    int clearFails = 0;
    int holdFails = 0;
    int failures;

    assign failures = predFails + branchFails + clearFails + holdFails;

    predNeedsBranch: assert property (@(posedge clk) disable iff (rst) predTakeD |-> branchD)
        else begin
            predFails++;
            $error("predTakeD high while branchD is low");
        end

    branchNeedsValid: assert property (@(posedge clk) disable iff (rst) branchD |-> validD)
        else begin
            branchFails++;
            $error("branchD high while validD is low");
        end

    // slot is empty right after a reset or flush edge
    clearEmptiesSlot: assert property (@(posedge clk) (rst || flush) |=> !validD)
        else begin
            clearFails++;
            $error("validD high after reset or flush");
        end

    stallHoldsPc: assert property (@(posedge clk) (stall && !flush && !rst) |=> $stable(pcD))
        else begin
            holdFails++;
            $error("pcD changed across a stalled cycle");
        end

endmodule

bind bpFrontEnd bpFrontEnd_checker assertChecker (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .flush    (flush),
    .validD   (validD),
    .pcD      (pcD),
    .branchD  (branchD),
    .predTakeD(predTakeD)
);

//--- verif/tbBpFrontEnd.sv
`timescale 1ns/1ps

module tbBpFrontEnd;

    import mipsPkg::*;

    localparam logic [31:0] resetPc       = 32'hBFC00000;
    localparam int          indexBits     = 10;
    localparam int          historyBits   = 6;
    localparam int          stimCycles    = 4000;
    localparam int          timeoutCycles = stimCycles + 100;
    localparam int          memWords      = 1024;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic        redirect;
    logic [31:0] redirectPc;
    instrT       instrF2;
    logic        branchE;
    logic [31:0] pcE;
    logic        actualTakeE;
    logic [31:0] pcF2;
    logic        validD;
    logic [31:0] pcD;
    instrT       instrD;
    logic        branchD;
    logic        predTakeD;

    // reference state
    logic [31:0]            modelPc = resetPc;
    logic                   modelValid;
    logic [31:0]            modelPcD;
    instrT                  modelInstrD;
    logic                   modelPred;
    logic [historyBits-1:0] modelHist [1 << indexBits];
    // counter strength 0..3, taken from 2 up
    int                     modelLevel [1 << historyBits];

    instrT       imem [memWords];
    logic [31:0] branchPcs [8];
    int          takeBias [8];
    int          patternPos = 0;
    int          stimCount = 0;
    logic        stimDone = 1'b0;
    logic        started = 1'b0;
    int          cycleCount = 0;
    int          seedDummy;

    clkGen clockSource (
        .clk(clk),
        .rst(rst)
    );

    bpFrontEnd i_dut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrF2    (instrF2),
        .branchE    (branchE),
        .pcE        (pcE),
        .actualTakeE(actualTakeE),
        .pcF2       (pcF2),
        .validD     (validD),
        .pcD        (pcD),
        .instrD     (instrD),
        .branchD    (branchD),
        .predTakeD  (predTakeD)
    );

    // REGIMM with rt[4:3..1] pattern x00x, or opcodes 4..7
    function automatic logic isBranchWord(logic [31:0] word);
        logic [5:0] op;
        op = word[31:26];
        if (op == 6'd1) begin
            return word[19:18] == 2'b00;
        end
        return (op >= 6'd4) && (op <= 6'd7);
    endfunction

    function automatic instrT makeWord(logic forceBranch);
        logic [31:0] word;
        int kind;
        int sel;
        word = $urandom;
        kind = forceBranch ? $urandom % 40 : $urandom % 100;
        if (kind < 20) begin
            // bltz, bgez, links and likely forms
            word[31:26] = 6'b000001;
            word[19:18] = 2'b00;
        end else if (kind < 40) begin
            word[31:28] = 4'b0001;
        end else if (kind < 50) begin
            // REGIMM but not a branch
            sel = 2 + $urandom % 6;
            word[31:26] = 6'b000001;
            word[19:17] = sel[2:0];
        end else if (word[31:26] == 6'b000001 || word[31:28] == 4'b0001) begin
            word[31:26] = 6'b100011;
        end
        return word;
    endfunction

    task automatic fillMemory();
        logic forceBranch;
        for (int i = 0; i < memWords; i++) begin
            // trained PCs sit on every eighth word of the low window
            forceBranch = (i < 64) && (i % 8 == 0);
            imem[i] = makeWord(forceBranch);
        end
    endtask

    task automatic setupBranchSites();
        for (int k = 0; k < 8; k++) begin
            branchPcs[k] = resetPc + k * 32;
        end
        // site 0 runs a period-3 sequence, 1 and 2 saturate
        takeBias = '{0, 100, 0, 90, 10, 75, 25, 50};
    endtask

    task automatic updateModel();
        logic [indexBits-1:0]   lookupIdx;
        logic [indexBits-1:0]   updIdx;
        logic [historyBits-1:0] lookupHist;
        logic [historyBits-1:0] oldHist;
        logic                   predF2;
        lookupIdx  = modelPc[indexBits+1:2];
        lookupHist = modelHist[lookupIdx];
        predF2     = modelLevel[lookupHist] >= 2;
        if (rst) begin
            modelPc     = resetPc;
            modelValid  = 1'b0;
            modelPcD    = '0;
            modelInstrD = '0;
            modelPred   = 1'b0;
            for (int i = 0; i < (1 << indexBits); i++) begin
                modelHist[i] = '0;
            end
            for (int i = 0; i < (1 << historyBits); i++) begin
                modelLevel[i] = 0;
            end
        end else begin
            if (flush) begin
                modelValid  = 1'b0;
                modelPcD    = '0;
                modelInstrD = '0;
                modelPred   = 1'b0;
            end else if (!stall) begin
                modelValid  = 1'b1;
                modelPcD    = modelPc;
                modelInstrD = instrF2;
                modelPred   = predF2;
            end
            if (redirect) begin
                modelPc = redirectPc;
            end else if (!stall) begin
                modelPc = modelPc + 32'd4;
            end
            // trains even while stalled
            if (branchE) begin
                updIdx  = pcE[indexBits+1:2];
                oldHist = modelHist[updIdx];
                if (actualTakeE && modelLevel[oldHist] < 3) begin
                    modelLevel[oldHist] = modelLevel[oldHist] + 1;
                end else if (!actualTakeE && modelLevel[oldHist] > 0) begin
                    modelLevel[oldHist] = modelLevel[oldHist] - 1;
                end
                modelHist[updIdx] = {oldHist[historyBits-2:0], actualTakeE};
            end
        end
    endtask

    task automatic driveIdle();
        stall       <= 1'b0;
        flush       <= 1'b0;
        redirect    <= 1'b0;
        redirectPc  <= resetPc;
        branchE     <= 1'b0;
        pcE         <= resetPc;
        actualTakeE <= 1'b0;
        instrF2     <= imem[modelPc[11:2]];
    endtask

    task automatic driveStimulus();
        logic strobe;
        logic take;
        int   pick;
        strobe = ($urandom % 2) == 1;
        pick   = $urandom % 8;
        if (pick == 0) begin
            // taken, taken, not taken
            take = patternPos != 2;
            if (strobe) begin
                patternPos = (patternPos + 1) % 3;
            end
        end else begin
            take = ($urandom % 100) < takeBias[pick];
        end
        stall       <= ($urandom % 8) == 0;
        flush       <= ($urandom % 16) == 0;
        redirect    <= ($urandom % 32) == 0;
        redirectPc  <= resetPc + ($urandom % 64) * 4;
        branchE     <= strobe;
        pcE         <= branchPcs[pick];
        actualTakeE <= take;
        // word for the PC that F2 holds after this edge
        instrF2     <= imem[modelPc[11:2]];
        stimCount++;
        if (stimCount == stimCycles) begin
            stimDone = 1'b1;
        end
    endtask

    task automatic checkPc(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkInstr(string name, instrT expected, instrT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkOutputs();
        logic expBranch;
        expBranch = modelValid && isBranchWord(modelInstrD);
        checkPc("pcF2", modelPc, pcF2);
        checkBit("validD", modelValid, validD);
        checkPc("pcD", modelPcD, pcD);
        checkInstr("instrD", modelInstrD, instrD);
        checkBit("branchD", expBranch, branchD);
        checkBit("predTakeD", expBranch && modelPred, predTakeD);
    endtask

    always @(posedge clk) begin
        updateModel();
        started = 1'b1;
        if (rst || stimDone) begin
            driveIdle();
        end else begin
            driveStimulus();
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (started) begin
            checkOutputs();
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seedDummy = $urandom(32'h68d50411);
        stall       <= 1'b0;
        flush       <= 1'b0;
        redirect    <= 1'b0;
        redirectPc  <= resetPc;
        branchE     <= 1'b0;
        pcE         <= resetPc;
        actualTakeE <= 1'b0;
        setupBranchSites();
        fillMemory();
        instrF2 <= imem[resetPc[11:2]];
        wait (stimDone);
        // let the last decode slot reach a compare
        repeat (3) @(posedge clk);
        if (i_dut.assertChecker.failures == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("assertion checker counted %0d failures", i_dut.assertChecker.failures);
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- vlog.f
rtl/mipsPkg.sv
rtl/bpPkg.sv
rtl/pcGen.sv
rtl/fetchDecodeReg.sv
rtl/localHistoryTable.sv
rtl/patternCounterTable.sv
rtl/branchPredictor.sv
rtl/bpFrontEnd.sv
verif/clkGen.sv
verif/bpFrontEnd_checker.sv
verif/tbBpFrontEnd.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbBpFrontEnd
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
